//--- hdl/lsu_pkg.sv
/*
  Load/store unit shared definitions
  Bus widths, byte lane helpers, access size encoding and the
  default limit on outstanding bus transactions
*/

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////////////

  // Address and data bus widths
  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 32;

  // Lane helpers for byte and halfword selection
  parameter int unsigned BYTE_W = 8;
  parameter int unsigned HALF_W = 16;

  // One byte enable per data byte
  parameter int unsigned BE_W = DATA_W / BYTE_W;

  // Byte offset within a word
  parameter int unsigned OFFSET_W = $clog2(BE_W);

  ////////////////////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////////////////////

  // Encoding 3 is not named, it decodes as a word everywhere
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Default outstanding transaction limit
  parameter int unsigned MAX_OUTSTANDING_DEFAULT = 2;

endpackage

//--- hdl/lsu_req_gen.sv
/*
  Load/store request generation
  Effective address, byte enables, store data lane rotation and
  detection of accesses that need a second bus phase
*/

`timescale 1ns/1ps

module lsu_req_gen (
  input  logic                          ex_req_i,
  input  lsu_pkg::lsu_size_e            ex_size_i,
  input  logic                          ex_second_i,
  input  logic                          ex_use_incr_i,
  input  logic [lsu_pkg::ADDR_W-1:0]    ex_op_a_i,
  input  logic [lsu_pkg::ADDR_W-1:0]    ex_op_b_i,
  input  logic [lsu_pkg::DATA_W-1:0]    ex_wdata_i,
  input  logic [lsu_pkg::OFFSET_W-1:0]  ex_reg_offset_i,
  output logic [lsu_pkg::ADDR_W-1:0]    addr_o,
  output logic [lsu_pkg::OFFSET_W-1:0]  offset_o,
  output logic [lsu_pkg::BE_W-1:0]      be_o,
  output logic [lsu_pkg::DATA_W-1:0]    wdata_o,
  output logic                          misaligned_o
);

  // Unaligned effective address
  logic [lsu_pkg::ADDR_W-1:0]    eff_addr;
  // Store data lane shift in bytes
  logic [lsu_pkg::OFFSET_W-1:0]  wdata_shift;
  // Store data doubled up so a shift gives a rotation
  logic [2*lsu_pkg::DATA_W-1:0]  wdata_dbl;

  ////////////////////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////////////////////

  // Base only, or base plus increment
  assign eff_addr = ex_use_incr_i ? (ex_op_a_i + ex_op_b_i) : ex_op_a_i;

  // Byte offset of the first phase, also used for read alignment
  assign offset_o = eff_addr[lsu_pkg::OFFSET_W-1:0];

  // Second phase always starts at the next word boundary
  // (the pipeline has already advanced the operands)
  assign addr_o = ex_second_i ?
                  {eff_addr[lsu_pkg::ADDR_W-1:lsu_pkg::OFFSET_W], {lsu_pkg::OFFSET_W{1'b0}}} :
                  eff_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ex_size_i)
      lsu_pkg::SIZE_BYTE:
      begin
        // Single lane at the offset
        case (offset_o)
          2'd0:    be_o = 4'b0001;
          2'd1:    be_o = 4'b0010;
          2'd2:    be_o = 4'b0100;
          default: be_o = 4'b1000;
        endcase
      end
      lsu_pkg::SIZE_HALF:
      begin
        if (!ex_second_i)
        begin
          // Offset 3 only gets the top lane in this phase
          case (offset_o)
            2'd0:    be_o = 4'b0011;
            2'd1:    be_o = 4'b0110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
        else
        begin
          // Remaining byte of a split half
          be_o = 4'b0001;
        end
      end
      default:
      begin
        if (!ex_second_i)
        begin
          // Upper lanes from the offset
          case (offset_o)
            2'd0:    be_o = 4'b1111;
            2'd1:    be_o = 4'b1110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
        else
        begin
          // Lower lanes left over from the first phase
          case (offset_o)
            2'd0:    be_o = 4'b0000;
            2'd1:    be_o = 4'b0001;
            2'd2:    be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store data
  ////////////////////////////////////////////////////////////////////////////

  // Register offset already accounts for part of the lane move
  assign wdata_shift = offset_o - ex_reg_offset_i;

  // Upper half of the shifted pair is the rotated word
  assign wdata_dbl = {ex_wdata_i, ex_wdata_i} << (lsu_pkg::BYTE_W * wdata_shift);
  assign wdata_o   = wdata_dbl[2*lsu_pkg::DATA_W-1 -: lsu_pkg::DATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // Misalignment
  ////////////////////////////////////////////////////////////////////////////

  // Only a first phase can ask for another phase
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_req_i && !ex_second_i)
    begin
      case (ex_size_i)
        lsu_pkg::SIZE_BYTE: misaligned_o = 1'b0;
        lsu_pkg::SIZE_HALF: misaligned_o = (offset_o == 2'd3);
        default:            misaligned_o = (offset_o != 2'd0);
      endcase
    end
  end

endmodule

//--- hdl/lsu_txn_counter.sv
/*
  Outstanding transaction counter
  Gates bus requests at the limit and derives the execute and
  writeback ready levels and the busy flag
*/

`timescale 1ns/1ps

module lsu_txn_counter #(
  parameter int unsigned DEPTH = lsu_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic ex_req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic txn_accept_o,
  output logic wb_update_o,
  output logic ready_ex_o,
  output logic ready_wb_o,
  output logic busy_o
);

  // Counter must hold the value DEPTH itself
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  // Request only while below the limit
  assign data_req_o   = ex_req_i && (cnt_q < CNT_MAX);
  assign txn_accept_o = data_req_o && data_gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // Count
  ////////////////////////////////////////////////////////////////////////////

  // Up on accept, down on response, hold when both
  always_comb
  begin
    case ({txn_accept_o, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + CNT_ONE;
      2'b01:   cnt_d = cnt_q - CNT_ONE;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ready levels
  ////////////////////////////////////////////////////////////////////////////

  // With WB occupied, EX and WB move in lock step on the response
  always_comb
  begin
    if (!ex_req_i)
      ready_ex_o = 1'b1;
    else if (cnt_q == '0)
      ready_ex_o = txn_accept_o;
    else if (cnt_q == CNT_ONE)
      ready_ex_o = txn_accept_o && data_rvalid_i;
    else
      ready_ex_o = data_rvalid_i;
  end

  // WB idle, or its awaited response is here
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // Access moves on to WB
  assign wb_update_o = ready_ex_o && ex_req_i;

  assign busy_o = (cnt_q != '0) || data_req_o;

endmodule

//--- hdl/lsu_rdata_align.sv
/*
  Read data alignment
  Holds the writeback control of the access in flight, selects and
  extends the loaded byte, half or word and joins split loads
*/

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wb_update_i,
  input  logic                          ex_we_i,
  input  lsu_pkg::lsu_size_e            ex_size_i,
  input  logic                          ex_sign_ext_i,
  input  logic                          ex_second_i,
  input  logic                          misaligned_i,
  input  logic [lsu_pkg::OFFSET_W-1:0]  offset_i,
  input  logic                          data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]    data_rdata_i,
  output logic [lsu_pkg::DATA_W-1:0]    rdata_o
);

  // Writeback control of the access in flight
  lsu_pkg::lsu_size_e            size_q;
  logic [lsu_pkg::OFFSET_W-1:0]  offset_q;
  logic                          sign_ext_q;
  logic                          we_q;

  // Raw first half of a split load, or the last result
  logic [lsu_pkg::DATA_W-1:0]    hold_q;

  // Response shifted down to the addressed lane
  logic [lsu_pkg::DATA_W-1:0]    rdata_shr;
  // New word over held word, shifted for a split access
  logic [2*lsu_pkg::DATA_W-1:0]  rdata_join;

  logic [lsu_pkg::BYTE_W-1:0]    sel_byte;
  logic [lsu_pkg::HALF_W-1:0]    sel_half;
  logic [lsu_pkg::DATA_W-1:0]    sel_word;
  logic [lsu_pkg::DATA_W-1:0]    rdata_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Writeback control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= lsu_pkg::SIZE_BYTE;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (wb_update_i)
    begin
      size_q     <= ex_size_i;
      offset_q   <= offset_i;
      sign_ext_q <= ex_sign_ext_i;
      we_q       <= ex_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_shr  = data_rdata_i >> (lsu_pkg::BYTE_W * offset_q);

  // Upper bytes of the held word continue into the new word
  assign rdata_join = {data_rdata_i, hold_q} >> (lsu_pkg::BYTE_W * offset_q);

  assign sel_byte = rdata_shr[lsu_pkg::BYTE_W-1:0];

  // Half at offset 3 straddles the word boundary
  assign sel_half = (offset_q == 2'd3) ? rdata_join[lsu_pkg::HALF_W-1:0] :
                                         rdata_shr[lsu_pkg::HALF_W-1:0];

  // Aligned word straight from the bus, else joined
  assign sel_word = (offset_q == 2'd0) ? data_rdata_i :
                                         rdata_join[lsu_pkg::DATA_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_q)
      lsu_pkg::SIZE_BYTE:
        rdata_ext = {{(lsu_pkg::DATA_W-lsu_pkg::BYTE_W){sign_ext_q & sel_byte[lsu_pkg::BYTE_W-1]}},
                     sel_byte};
      lsu_pkg::SIZE_HALF:
        rdata_ext = {{(lsu_pkg::DATA_W-lsu_pkg::HALF_W){sign_ext_q & sel_half[lsu_pkg::HALF_W-1]}},
                     sel_half};
      // Word needs no extension
      default:
        rdata_ext = sel_word;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hold register
  ////////////////////////////////////////////////////////////////////////////

  // Raw word while a split access is still in EX, final value otherwise
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
    begin
      if (ex_second_i || misaligned_i)
        hold_q <= data_rdata_i;
      else
        hold_q <= rdata_ext;
    end
  end

  // Live value during the response, held value after it
  assign rdata_o = data_rvalid_i ? rdata_ext : hold_q;

endmodule

//--- hdl/lsu_top.sv
/*
  Load/store unit data side
  Turns execute-stage accesses into bus requests, tracks outstanding
  transactions, aligns read data and reports bus errors
*/

`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned DEPTH = lsu_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // Execute stage
  input  logic                          ex_req_i,
  input  logic                          ex_we_i,
  input  lsu_pkg::lsu_size_e            ex_size_i,
  input  logic                          ex_sign_ext_i,
  input  logic                          ex_second_i,
  input  logic                          ex_use_incr_i,
  input  logic [lsu_pkg::ADDR_W-1:0]    ex_op_a_i,
  input  logic [lsu_pkg::ADDR_W-1:0]    ex_op_b_i,
  input  logic [lsu_pkg::DATA_W-1:0]    ex_wdata_i,
  input  logic [lsu_pkg::OFFSET_W-1:0]  ex_reg_offset_i,
  input  logic                          block_addr_i,

  // Data bus
  output logic                          data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]    data_addr_o,
  output logic                          data_we_o,
  output logic [lsu_pkg::BE_W-1:0]      data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]    data_wdata_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]    data_rdata_i,
  input  logic                          data_err_i,

  // Pipeline status
  output logic                          misaligned_o,
  output logic                          ready_ex_o,
  output logic                          ready_wb_o,
  output logic [lsu_pkg::DATA_W-1:0]    rdata_o,
  output logic                          busy_o,
  output logic                          err_o,
  output logic [lsu_pkg::ADDR_W-1:0]    err_addr_o
);

  logic [lsu_pkg::ADDR_W-1:0]    req_addr;
  logic [lsu_pkg::OFFSET_W-1:0]  req_offset;
  logic [lsu_pkg::BE_W-1:0]      req_be;
  logic [lsu_pkg::DATA_W-1:0]    req_wdata;
  logic                          txn_accept;
  logic                          wb_update;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  lsu_req_gen i_req_gen (
    .ex_req_i        (ex_req_i),
    .ex_size_i       (ex_size_i),
    .ex_second_i     (ex_second_i),
    .ex_use_incr_i   (ex_use_incr_i),
    .ex_op_a_i       (ex_op_a_i),
    .ex_op_b_i       (ex_op_b_i),
    .ex_wdata_i      (ex_wdata_i),
    .ex_reg_offset_i (ex_reg_offset_i),
    .addr_o          (req_addr),
    .offset_o        (req_offset),
    .be_o            (req_be),
    .wdata_o         (req_wdata),
    .misaligned_o    (misaligned_o)
  );

  // Bus fields follow the execute stage directly
  assign data_addr_o  = req_addr;
  assign data_we_o    = ex_we_i;
  assign data_be_o    = req_be;
  assign data_wdata_o = req_wdata;

  lsu_txn_counter #(
    .DEPTH (DEPTH)
  ) i_txn_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_req_i      (ex_req_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .txn_accept_o  (txn_accept),
    .wb_update_o   (wb_update),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  lsu_rdata_align i_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_update_i   (wb_update),
    .ex_we_i       (ex_we_i),
    .ex_size_i     (ex_size_i),
    .ex_sign_ext_i (ex_sign_ext_i),
    .ex_second_i   (ex_second_i),
    .misaligned_i  (misaligned_o),
    .offset_i      (req_offset),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_o       (rdata_o)
  );

  // Last granted address, frozen by the pipeline after an error
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_addr_o <= '0;
    else if (txn_accept && !block_addr_i)
      err_addr_o <= req_addr;
  end

  // Error only counts with its response
  assign err_o = data_rvalid_i && data_err_i;

endmodule

//--- tb/tb_bus_responder.sv
/*
  Data bus responder
  Word memory behind a req/gnt/rvalid bus with random grant and
  response delays, in-order responses and random bus errors
*/

`timescale 1ns/1ps

module tb_bus_responder #(
  parameter logic [31:0] SEED    = 32'h4da0311b,
  parameter int          GNT_MAX = 3,
  parameter int          RSP_MAX = 6
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,
  output logic        data_err_o
);

  // 16 words, indexed by address bits 5:2
  logic [31:0] mem [16];

  logic [31:0] rng;
  int          gnt_wait;
  int          cycle;
  int          last_due;
  // Pending responses as {err, rdata} with the cycle each may go out
  logic [32:0] rsp_q [$];
  int          due_q [$];

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial
  begin
    logic [3:0] idx;
    int         due;
    logic       err;
    // Fill from the full byte address of each word
    for (int i = 0; i < 16; i++)
      mem[i] = 32'(i * 4) * 32'h9e3779b9 + 32'h13579bdf;
    rng           = SEED;
    gnt_wait      = 0;
    cycle         = 0;
    last_due      = -1;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    data_err_o    = 1'b0;
    forever
    begin
      // Sample the bus mid-cycle
      @(negedge clk);
      if (rst_n && data_req_i && data_gnt_o)
      begin
        idx = data_addr_i[5:2];
        if (data_we_i)
        begin
          for (int b = 0; b < 4; b++)
            if (data_be_i[b])
              mem[idx][8*b +: 8] = data_wdata_i[8*b +: 8];
        end
        rng = xorshift(rng);
        due = cycle + int'(rng[15:0]) % (RSP_MAX + 1);
        // Responses stay in order
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        err = (rng[18:16] == 3'd0);
        rsp_q.push_back({err, data_we_i ? 32'h0 : mem[idx]});
        due_q.push_back(due);
        gnt_wait = int'(rng[25:24]) % (GNT_MAX + 1);
      end
      else if (data_req_i && gnt_wait > 0)
      begin
        gnt_wait = gnt_wait - 1;
      end
      // Drive just after the next rising edge
      @(posedge clk);
      #2;
      data_gnt_o = (gnt_wait == 0);
      if (due_q.size() > 0 && due_q[0] <= cycle)
      begin
        {data_err_o, data_rdata_o} = rsp_q.pop_front();
        void'(due_q.pop_front());
        data_rvalid_o = 1'b1;
      end
      else
      begin
        data_rvalid_o = 1'b0;
        data_err_o    = 1'b0;
      end
      cycle = cycle + 1;
    end
  end

endmodule

//--- tb/tb_lsu_top.sv
/*
  Load/store unit testbench
  Random loads and stores of every size and offset against a
  reference byte memory, with cycle by cycle checks of the bus side
*/

`timescale 1ns/1ps

module tb_lsu_top;

  localparam int DEPTH       = int'(lsu_pkg::MAX_OUTSTANDING_DEFAULT);
  localparam int N_ACC       = 300;
  localparam int GNT_MAX     = 3;
  localparam int RSP_MAX     = 6;
  localparam int MAX_DELAY   = GNT_MAX + RSP_MAX;
  // Up to two phases per access
  localparam int WATCHDOG_NS = N_ACC * 2 * (MAX_DELAY + 4) * 20;

  logic clk;
  logic rst_n;

  logic               ex_req;
  logic               ex_we;
  lsu_pkg::lsu_size_e ex_size;
  logic               ex_sign_ext;
  logic               ex_second;
  logic               ex_use_incr;
  logic [31:0]        ex_op_a;
  logic [31:0]        ex_op_b;
  logic [31:0]        ex_wdata;
  logic [1:0]         ex_reg_offset;
  logic               block_addr;

  logic        data_req;
  logic [31:0] data_addr;
  logic        data_we;
  logic [3:0]  data_be;
  logic [31:0] data_wdata;
  logic        data_gnt;
  logic        data_rvalid;
  logic [31:0] data_rdata;
  logic        data_err;

  logic        misaligned;
  logic        ready_ex;
  logic        ready_wb;
  logic [31:0] rdata;
  logic        busy;
  logic        err;
  logic [31:0] err_addr;

  // Expected bus fields of the phase in EX
  logic [31:0] exp_addr;
  logic [3:0]  exp_be;
  logic [31:0] exp_wdata;
  logic        exp_mis;
  logic        cur_chk;
  logic [31:0] cur_val;

  logic [31:0] ref_mem [16];
  logic [32:0] exp_q [$];
  int          tcnt;
  logic [31:0] ea_model;
  logic [31:0] rng;

  lsu_top #(
    .DEPTH (DEPTH)
  ) i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_i        (ex_req),
    .ex_we_i         (ex_we),
    .ex_size_i       (ex_size),
    .ex_sign_ext_i   (ex_sign_ext),
    .ex_second_i     (ex_second),
    .ex_use_incr_i   (ex_use_incr),
    .ex_op_a_i       (ex_op_a),
    .ex_op_b_i       (ex_op_b),
    .ex_wdata_i      (ex_wdata),
    .ex_reg_offset_i (ex_reg_offset),
    .block_addr_i    (block_addr),
    .data_req_o      (data_req),
    .data_addr_o     (data_addr),
    .data_we_o       (data_we),
    .data_be_o       (data_be),
    .data_wdata_o    (data_wdata),
    .data_gnt_i      (data_gnt),
    .data_rvalid_i   (data_rvalid),
    .data_rdata_i    (data_rdata),
    .data_err_i      (data_err),
    .misaligned_o    (misaligned),
    .ready_ex_o      (ready_ex),
    .ready_wb_o      (ready_wb),
    .rdata_o         (rdata),
    .busy_o          (busy),
    .err_o           (err),
    .err_addr_o      (err_addr)
  );

  tb_bus_responder #(
    .SEED    (32'h4da0311b),
    .GNT_MAX (GNT_MAX),
    .RSP_MAX (RSP_MAX)
  ) i_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req),
    .data_addr_i   (data_addr),
    .data_we_i     (data_we),
    .data_be_i     (data_be),
    .data_wdata_i  (data_wdata),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_rdata_o  (data_rdata),
    .data_err_o    (data_err)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    assert (ok === 1'b1)
    else
    begin
      $display("Error: %s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lanes touched by one phase of an access of sz bytes at offset o
  function automatic logic [3:0] lanes_of(input int o, input int sz, input logic second);
    logic [3:0] be;
    be = 4'b0000;
    for (int l = 0; l < 4; l++)
      if (second ? (l < o + sz - 4) : (l >= o && l < o + sz))
        be[l] = 1'b1;
    return be;
  endfunction

  // Store byte j of the access lands in lane (o + j), taken from byte (j + r)
  function automatic logic [31:0] lane_wdata(input logic [31:0] w, input int o, input int r);
    logic [31:0] res;
    res = '0;
    for (int l = 0; l < 4; l++)
      res[8*l +: 8] = w[8*((l - o + r) & 3) +: 8];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    logic        acc;
    logic        e_rdy;
    logic [32:0] ent;
    if (!rst_n)
    begin
      tcnt     = 0;
      ea_model = '0;
    end
    else
    begin
      // Accept as the bus rules predict it from the own count
      acc = ex_req && (tcnt < DEPTH) && data_gnt;
      check_cond(tcnt <= DEPTH, "outstanding count above limit");
      check_val("data_req_o", 32'(data_req), 32'(ex_req && (tcnt < DEPTH)));
      check_val("busy_o", 32'(busy), 32'((tcnt != 0) || ex_req));
      // Ready levels from the own count
      if (!ex_req)
        e_rdy = 1'b1;
      else if (tcnt == 0)
        e_rdy = acc;
      else if (tcnt == 1)
        e_rdy = acc && data_rvalid;
      else
        e_rdy = data_rvalid;
      check_val("ready_ex_o", 32'(ready_ex), 32'(e_rdy));
      check_val("ready_wb_o", 32'(ready_wb), 32'((tcnt == 0) ? 1'b1 : data_rvalid));
      check_val("misaligned_o", 32'(misaligned), 32'(ex_req && exp_mis));
      check_val("err_o", 32'(err), 32'(data_rvalid && data_err));
      check_val("err_addr_o", err_addr, ea_model);
      if (acc)
      begin
        check_val("data_addr_o", data_addr, exp_addr);
        check_val("data_be_o", 32'(data_be), 32'(exp_be));
        check_val("data_we_o", 32'(data_we), 32'(ex_we));
        // Only enabled lanes carry store data
        if (ex_we)
          check_val("data_wdata_o", data_wdata, exp_wdata);
        exp_q.push_back({cur_chk, cur_val});
        if (!block_addr)
          ea_model = exp_addr;
        tcnt = tcnt + 1;
      end
      if (data_rvalid)
      begin
        check_cond(exp_q.size() > 0, "response without an accepted request");
        ent = exp_q.pop_front();
        if (ent[32])
          check_val("rdata_o", rdata, ent[31:0]);
        tcnt = tcnt - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Hold the phase until EX reports ready at a clock edge
  task automatic run_phase();
    logic done;
    ex_req = 1'b1;
    done   = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = ready_ex;
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] ba;
    logic [31:0] v;
    int          o;
    int          sz;
    int          r;
    int          idle;
    logic        mis;
    clk           = 1'b0;
    rst_n         = 1'b0;
    ex_req        = 1'b0;
    ex_we         = 1'b0;
    ex_size       = lsu_pkg::SIZE_BYTE;
    ex_sign_ext   = 1'b0;
    ex_second     = 1'b0;
    ex_use_incr   = 1'b0;
    ex_op_a       = '0;
    ex_op_b       = '0;
    ex_wdata      = '0;
    ex_reg_offset = '0;
    block_addr    = 1'b0;
    exp_addr      = '0;
    exp_be        = '0;
    exp_wdata     = '0;
    exp_mis       = 1'b0;
    cur_chk       = 1'b0;
    cur_val       = '0;
    rng           = 32'h4da0311b;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < 16; i++)
      ref_mem[i] = i_mem.mem[i];

    for (int n = 0; n < N_ACC; n++)
    begin
      rng = xorshift(rng);
      a   = rng & 32'h3f;
      b   = (rng >> 6) & 32'h7;
      ex_use_incr   = rng[9];
      ex_we         = rng[10];
      ex_sign_ext   = rng[11];
      ex_size       = lsu_pkg::lsu_size_e'(rng[13:12]);
      ex_reg_offset = rng[15:14];
      block_addr    = (rng[17:16] == 2'd0);
      rng      = xorshift(rng);
      ex_wdata = rng;
      ea = ex_use_incr ? a + b : a;
      o  = int'(ea & 32'h3);
      r  = int'(ex_reg_offset);
      // Encoding 3 behaves as a word
      sz  = (ex_size == lsu_pkg::SIZE_BYTE) ? 1 : (ex_size == lsu_pkg::SIZE_HALF) ? 2 : 4;
      mis = (sz == 4 && o != 0) || (sz == 2 && o == 3);

      // Reference access in byte order
      v = '0;
      for (int j = 0; j < sz; j++)
      begin
        ba = ea + 32'(j);
        if (ex_we)
          ref_mem[ba[5:2]][8*ba[1:0] +: 8] = ex_wdata[8*((j + r) & 3) +: 8];
        else
          v[8*j +: 8] = ref_mem[ba[5:2]][8*ba[1:0] +: 8];
      end
      if (ex_sign_ext && sz == 1 && v[7])
        v = v | 32'hffffff00;
      if (ex_sign_ext && sz == 2 && v[15])
        v = v | 32'hffff0000;

      // First phase
      ex_op_a   = a;
      ex_op_b   = b;
      ex_second = 1'b0;
      exp_addr  = ea;
      exp_be    = lanes_of(o, sz, 1'b0);
      exp_wdata = lane_wdata(ex_wdata, o, r);
      exp_mis   = mis;
      cur_chk   = !ex_we && !mis;
      cur_val   = v;
      run_phase();

      // Second phase at the next word, same offset
      if (mis)
      begin
        ex_op_a   = a + 32'd4;
        ex_second = 1'b1;
        exp_addr  = (ea + 32'd4) & ~32'h3;
        exp_be    = lanes_of(o, sz, 1'b1);
        exp_mis   = 1'b0;
        cur_chk   = !ex_we;
        run_phase();
      end

      // Occasional gap lets the bus drain
      ex_req    = 1'b0;
      ex_second = 1'b0;
      exp_mis   = 1'b0;
      rng       = xorshift(rng);
      idle      = (rng[1:0] == 2'd0) ? int'(rng[3:2]) : 0;
      repeat (idle)
      begin
        @(posedge clk);
        #2;
      end
    end

    ex_req = 1'b0;
    while (tcnt != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    check_cond(exp_q.size() == 0, "responses missing at end of run");
    for (int i = 0; i < 16; i++)
      check_val($sformatf("mem[%0d]", i), i_mem.mem[i], ref_mem[i]);
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Error: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- vlog.f
hdl/lsu_pkg.sv
hdl/lsu_req_gen.sv
hdl/lsu_txn_counter.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
tb/tb_bus_responder.sv
tb/tb_lsu_top.sv

//--- Makefile
# Verilator build of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
